// File: design/sd_macros.svh
`ifndef SD_MACROS_SVH
`define SD_MACROS_SVH

// bytes per data block kept small for simulation
`define SD_BLOCK_BYTES 16
`define SD_BLOCK_BITS (`SD_BLOCK_BYTES * 8)

// clock cycles per sck half period
`define SD_SCK_DIV 2

// 0xff bytes polled before giving up on a response
`define SD_RESP_TIMEOUT 16

// idle bytes with cs_n high before CMD0 give 80 clocks
`define SD_INIT_CLOCKS 10

`endif

// File: design/sd_pkg.sv
package sd_pkg;

  typedef enum logic [3:0] {
    INIT_IDLE,
    CMD0,
    APP_CMD,
    ACMD41,
    READY,
    SEND_CMD,
    WAIT_R1,
    WAIT_TOKEN,
    XFER_DATA,
    XFER_CRC,
    WAIT_DRESP,
    WAIT_BUSY,
    DONE,
    FAIL
  } ctrl_state_e;

  typedef enum logic [5:0] {
    CMD_GO_IDLE = 6'd0,
    CMD_READ    = 6'd17,
    CMD_WRITE   = 6'd24,
    CMD_APP     = 6'd55,
    ACMD_OP     = 6'd41
  } cmd_e;

  localparam logic [7:0] DATA_TOKEN = 8'hfe;
  localparam logic [7:0] R1_IDLE    = 8'h01;
  localparam logic [7:0] DRESP_OK   = 8'h05;

endpackage

// File: design/sd_spi_if.sv
`timescale 1ns/1ps

interface sd_spi_if;
  logic       start;
  logic [7:0] tx_byte;
  logic       cs_n_hold;
  logic [7:0] rx_byte;
  logic       done;

  modport ctrl (
    output start,
    output tx_byte,
    output cs_n_hold,
    input  rx_byte,
    input  done
  );

  modport phy (
    input  start,
    input  tx_byte,
    input  cs_n_hold,
    output rx_byte,
    output done
  );
endinterface

// File: design/sd_spi_shifter.sv
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_spi_shifter (
  input  logic       clock,
  input  logic       arst_n,
  sd_spi_if.phy      spi,
  input  logic       miso,
  output logic       sck,
  output logic       mosi,
  output logic       cs_n
);

  logic       active;
  logic [7:0] div_cnt;
  logic [2:0] bit_cnt;
  logic [7:0] tx_sh;
  logic [7:0] rx_sh;
  logic       tick;
  logic       rise;
  logic       fall;

  assign tick = active && (div_cnt == `SD_SCK_DIV - 1);
  assign rise = tick && !sck;
  assign fall = tick && sck;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      active   <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      sck      <= 1'b0;
      mosi     <= 1'b1;
      cs_n     <= 1'b1;
      spi.done <= 1'b0;
    end else begin
      spi.done <= 1'b0;
      cs_n     <= spi.cs_n_hold;
      if (spi.start && !active) begin
        active  <= 1'b1;
        // first half period is one cycle shorter to absorb the start cycle
        div_cnt <= 8'd1;
        bit_cnt <= '0;
        mosi    <= spi.tx_byte[7];
      end else if (active) begin
        div_cnt <= tick ? 8'd0 : div_cnt + 8'd1;
        if (tick) begin
          sck <= ~sck;
        end
        if (fall) begin
          if (bit_cnt == 3'd7) begin
            active   <= 1'b0;
            spi.done <= 1'b1;
            mosi     <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 3'd1;
            mosi    <= tx_sh[6];
          end
        end
      end
    end
  end

  // data path
  always_ff @(posedge clock) begin
    if (spi.start && !active) begin
      tx_sh <= spi.tx_byte;
    end else if (fall) begin
      tx_sh <= {tx_sh[6:0], 1'b1};
    end
    if (rise) begin
      rx_sh <= {rx_sh[6:0], miso};
    end
    if (fall && bit_cnt == 3'd7) begin
      spi.rx_byte <= rx_sh;
    end
  end

  // idle bus keeps sck low
  assert property (@(posedge clock) disable iff (!arst_n)
    (cs_n && !active) |-> !sck);

endmodule

// File: design/sd_byte_counter.sv
`timescale 1ns/1ps

module sd_byte_counter (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        load,
  input  logic [15:0] value,
  input  logic        dec,
  output logic        zero
);

  logic [15:0] count;

  assign zero = (count == 16'd0);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (load) begin
      count <= value;
    end else if (dec && !zero) begin
      count <= count - 16'd1;
    end
  end

  assert property (@(posedge clock) disable iff (!arst_n) dec |-> !zero);

endmodule

// File: design/sd_crc.sv
`timescale 1ns/1ps

module sd_crc #(
  parameter int WIDTH = 7,
  parameter logic [WIDTH-1:0] POLY = 7'h09
) (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             clear,
  input  logic             strobe,
  input  logic [7:0]       data_byte,
  output logic [WIDTH-1:0] crc
);

  logic [WIDTH-1:0] next_crc;

  // eight serial steps msb first
  always_comb begin
    logic [WIDTH-1:0] c;
    logic             fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[WIDTH-1] ^ data_byte[i];
      c  = c << 1;
      if (fb) begin
        c = c ^ POLY;
      end
    end
    next_crc = c;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      crc <= '0;
    end else if (clear) begin
      crc <= '0;
    end else if (strobe) begin
      crc <= next_crc;
    end
  end

endmodule

// File: design/sd_controller.sv
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_controller (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      wr,
  input  logic [31:0]               addr,
  input  logic [`SD_BLOCK_BITS-1:0] wdata,
  output logic [`SD_BLOCK_BITS-1:0] rdata,
  output logic                      ack,
  output logic                      err,
  output logic                      ready,
  sd_spi_if.ctrl                    spi,
  output logic                      cnt_load,
  output logic [15:0]               cnt_value,
  output logic                      cnt_dec,
  input  logic                      cnt_zero,
  output logic                      crc7_clear,
  output logic                      crc7_strobe,
  output logic [7:0]                crc7_byte,
  input  logic [6:0]                crc7_value,
  output logic                      crc16_clear,
  output logic                      crc16_strobe,
  output logic [7:0]                crc16_byte,
  input  logic [15:0]               crc16_value
);

  localparam int BITS = `SD_BLOCK_BITS;

  sd_pkg::ctrl_state_e state;
  sd_pkg::ctrl_state_e last_state;
  sd_pkg::cmd_e        cmd_idx;
  logic                entry;
  logic                counted;
  logic                busy;
  logic                op_wr;
  logic [2:0]          fidx;
  logic [31:0]         arg;
  logic [39:0]         frame;
  logic [BITS-1:0]     wbuf;
  logic [15:0]         rx_crc;
  logic [7:0]          rx;

  assign rx = spi.rx_byte;

  // first cycle in a state loads the counter and lets zero settle
  assign entry = (state != last_state);

  always_comb begin
    counted = state inside {sd_pkg::INIT_IDLE, sd_pkg::WAIT_R1, sd_pkg::WAIT_TOKEN,
                            sd_pkg::XFER_DATA, sd_pkg::XFER_CRC, sd_pkg::WAIT_DRESP,
                            sd_pkg::WAIT_BUSY};
    case (state)
      sd_pkg::INIT_IDLE: cnt_value = 16'(`SD_INIT_CLOCKS);
      sd_pkg::XFER_DATA: cnt_value = 16'(`SD_BLOCK_BYTES);
      sd_pkg::XFER_CRC:  cnt_value = 16'd2;
      default:           cnt_value = 16'(`SD_RESP_TIMEOUT);
    endcase
  end

  assign cnt_load    = entry && counted;
  assign cnt_dec     = spi.done && counted;
  assign crc7_clear  = entry && (state == sd_pkg::SEND_CMD);
  assign crc16_clear = entry && (state == sd_pkg::XFER_DATA);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state         <= sd_pkg::INIT_IDLE;
      last_state    <= sd_pkg::FAIL;
      cmd_idx       <= sd_pkg::CMD_GO_IDLE;
      busy          <= 1'b0;
      op_wr         <= 1'b0;
      fidx          <= '0;
      arg           <= '0;
      frame         <= '0;
      wbuf          <= '0;
      rdata         <= '0;
      rx_crc        <= '0;
      ack           <= 1'b0;
      err           <= 1'b0;
      ready         <= 1'b0;
      spi.start     <= 1'b0;
      spi.tx_byte   <= 8'hff;
      spi.cs_n_hold <= 1'b1;
      crc7_strobe   <= 1'b0;
      crc7_byte     <= '0;
      crc16_strobe  <= 1'b0;
      crc16_byte    <= '0;
    end else begin
      last_state   <= state;
      spi.start    <= 1'b0;
      crc7_strobe  <= 1'b0;
      crc16_strobe <= 1'b0;
      ack          <= 1'b0;
      err          <= 1'b0;
      if (spi.done) begin
        busy <= 1'b0;
      end

      if (entry) begin
        fidx <= '0;
        if (state == sd_pkg::SEND_CMD) begin
          frame <= {2'b01, cmd_idx, arg};
        end
      end else begin
        case (state)
          sd_pkg::INIT_IDLE: begin
            if (!busy) begin
              if (cnt_zero) begin
                state <= sd_pkg::CMD0;
              end else begin
                spi.start   <= 1'b1;
                spi.tx_byte <= 8'hff;
                busy        <= 1'b1;
              end
            end
          end

          sd_pkg::CMD0, sd_pkg::APP_CMD, sd_pkg::ACMD41: begin
            cmd_idx <= (state == sd_pkg::CMD0)    ? sd_pkg::CMD_GO_IDLE :
                       (state == sd_pkg::APP_CMD) ? sd_pkg::CMD_APP : sd_pkg::ACMD_OP;
            arg           <= '0;
            spi.cs_n_hold <= 1'b0;
            state         <= sd_pkg::SEND_CMD;
          end

          sd_pkg::READY: begin
            if (cyc && stb && !ack) begin
              op_wr         <= wr;
              wbuf          <= wdata;
              arg           <= addr;
              cmd_idx       <= wr ? sd_pkg::CMD_WRITE : sd_pkg::CMD_READ;
              spi.cs_n_hold <= 1'b0;
              state         <= sd_pkg::SEND_CMD;
            end
          end

          sd_pkg::SEND_CMD: begin
            if (!busy) begin
              if (fidx == 3'd6) begin
                state <= sd_pkg::WAIT_R1;
              end else begin
                spi.start   <= 1'b1;
                busy        <= 1'b1;
                // last byte carries crc7 and the end bit
                spi.tx_byte <= (fidx == 3'd5) ? {crc7_value, 1'b1} : frame[39:32];
                if (fidx != 3'd5) begin
                  crc7_strobe <= 1'b1;
                  crc7_byte   <= frame[39:32];
                end
                frame <= frame << 8;
                fidx  <= fidx + 3'd1;
              end
            end
          end

          sd_pkg::WAIT_R1: begin
            if (spi.done) begin
              if (!rx[7]) begin
                case (cmd_idx)
                  sd_pkg::CMD_GO_IDLE: begin
                    state <= (rx == sd_pkg::R1_IDLE) ? sd_pkg::APP_CMD : sd_pkg::FAIL;
                  end
                  sd_pkg::CMD_APP: begin
                    state <= (rx[7:1] == 7'd0) ? sd_pkg::ACMD41 : sd_pkg::FAIL;
                  end
                  sd_pkg::ACMD_OP: begin
                    if (rx == 8'h00) begin
                      ready         <= 1'b1;
                      spi.cs_n_hold <= 1'b1;
                      state         <= sd_pkg::READY;
                    end else if (rx == sd_pkg::R1_IDLE) begin
                      state <= sd_pkg::APP_CMD;
                    end else begin
                      state <= sd_pkg::FAIL;
                    end
                  end
                  default: begin
                    state <= (rx == 8'h00) ? sd_pkg::WAIT_TOKEN : sd_pkg::FAIL;
                  end
                endcase
              end
            end else if (!busy) begin
              if (cnt_zero) begin
                state <= sd_pkg::FAIL;
              end else begin
                spi.start   <= 1'b1;
                spi.tx_byte <= 8'hff;
                busy        <= 1'b1;
              end
            end
          end

          sd_pkg::WAIT_TOKEN: begin
            if (spi.done) begin
              if (op_wr || rx == sd_pkg::DATA_TOKEN) begin
                state <= sd_pkg::XFER_DATA;
              end else if (rx != 8'hff) begin
                state <= sd_pkg::FAIL;
              end
            end else if (!busy) begin
              if (cnt_zero) begin
                state <= sd_pkg::FAIL;
              end else begin
                spi.start   <= 1'b1;
                spi.tx_byte <= op_wr ? sd_pkg::DATA_TOKEN : 8'hff;
                busy        <= 1'b1;
              end
            end
          end

          sd_pkg::XFER_DATA: begin
            if (spi.done) begin
              if (!op_wr) begin
                rdata        <= {rdata[BITS-9:0], rx};
                crc16_strobe <= 1'b1;
                crc16_byte   <= rx;
              end
            end else if (!busy) begin
              if (cnt_zero) begin
                state <= sd_pkg::XFER_CRC;
              end else begin
                spi.start   <= 1'b1;
                spi.tx_byte <= op_wr ? wbuf[BITS-1 -: 8] : 8'hff;
                busy        <= 1'b1;
                if (op_wr) begin
                  crc16_strobe <= 1'b1;
                  crc16_byte   <= wbuf[BITS-1 -: 8];
                  wbuf         <= wbuf << 8;
                end
              end
            end
          end

          sd_pkg::XFER_CRC: begin
            if (spi.done) begin
              rx_crc <= {rx_crc[7:0], rx};
            end else if (!busy) begin
              if (cnt_zero) begin
                if (op_wr) begin
                  state <= sd_pkg::WAIT_DRESP;
                end else begin
                  state <= (rx_crc == crc16_value) ? sd_pkg::DONE : sd_pkg::FAIL;
                end
              end else begin
                spi.start <= 1'b1;
                busy      <= 1'b1;
                fidx      <= fidx + 3'd1;
                if (!op_wr) begin
                  spi.tx_byte <= 8'hff;
                end else begin
                  spi.tx_byte <= (fidx == 3'd0) ? crc16_value[15:8] : crc16_value[7:0];
                end
              end
            end
          end

          sd_pkg::WAIT_DRESP, sd_pkg::WAIT_BUSY: begin
            if (spi.done) begin
              if (state == sd_pkg::WAIT_DRESP && rx != 8'hff) begin
                state <= (rx[4:0] == sd_pkg::DRESP_OK[4:0]) ? sd_pkg::WAIT_BUSY
                                                             : sd_pkg::FAIL;
              end else if (state == sd_pkg::WAIT_BUSY && rx != 8'h00) begin
                state <= sd_pkg::DONE;
              end
            end else if (!busy) begin
              if (cnt_zero) begin
                state <= sd_pkg::FAIL;
              end else begin
                spi.start   <= 1'b1;
                spi.tx_byte <= 8'hff;
                busy        <= 1'b1;
              end
            end
          end

          sd_pkg::DONE: begin
            ack           <= 1'b1;
            spi.cs_n_hold <= 1'b1;
            state         <= sd_pkg::READY;
          end

          default: begin
            spi.cs_n_hold <= 1'b1;
            // during init a failure restarts the power-up sequence
            if (ready) begin
              ack   <= 1'b1;
              err   <= 1'b1;
              state <= sd_pkg::READY;
            end else begin
              state <= sd_pkg::INIT_IDLE;
            end
          end
        endcase
      end
    end
  end

  assert property (@(posedge clock) disable iff (!arst_n) ack |=> !ack);

  // no new byte until the shifter reports the current one
  assert property (@(posedge clock) disable iff (!arst_n)
    spi.start |=> (!spi.start until_with spi.done));

  assert property (@(posedge clock) disable iff (!arst_n)
    (state == sd_pkg::READY) |-> spi.cs_n_hold);

endmodule

// File: design/sd_controller_top.sv
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_controller_top (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      wr,
  input  logic [31:0]               addr,
  input  logic [`SD_BLOCK_BITS-1:0] wdata,
  output logic [`SD_BLOCK_BITS-1:0] rdata,
  output logic                      ack,
  output logic                      err,
  output logic                      ready,
  input  logic                      miso,
  output logic                      cs_n,
  output logic                      sck,
  output logic                      mosi
);

  sd_spi_if spi_bus ();

  logic        cnt_load;
  logic [15:0] cnt_value;
  logic        cnt_dec;
  logic        cnt_zero;
  logic        crc7_clear;
  logic        crc7_strobe;
  logic [7:0]  crc7_byte;
  logic [6:0]  crc7_value;
  logic        crc16_clear;
  logic        crc16_strobe;
  logic [7:0]  crc16_byte;
  logic [15:0] crc16_value;

  sd_controller u_ctrl (
    .clock       (clock),
    .arst_n      (arst_n),
    .cyc         (cyc),
    .stb         (stb),
    .wr          (wr),
    .addr        (addr),
    .wdata       (wdata),
    .rdata       (rdata),
    .ack         (ack),
    .err         (err),
    .ready       (ready),
    .spi         (spi_bus.ctrl),
    .cnt_load    (cnt_load),
    .cnt_value   (cnt_value),
    .cnt_dec     (cnt_dec),
    .cnt_zero    (cnt_zero),
    .crc7_clear  (crc7_clear),
    .crc7_strobe (crc7_strobe),
    .crc7_byte   (crc7_byte),
    .crc7_value  (crc7_value),
    .crc16_clear (crc16_clear),
    .crc16_strobe(crc16_strobe),
    .crc16_byte  (crc16_byte),
    .crc16_value (crc16_value)
  );

  sd_spi_shifter u_shifter (
    .clock (clock),
    .arst_n(arst_n),
    .spi   (spi_bus.phy),
    .miso  (miso),
    .sck   (sck),
    .mosi  (mosi),
    .cs_n  (cs_n)
  );

  sd_byte_counter u_counter (
    .clock (clock),
    .arst_n(arst_n),
    .load  (cnt_load),
    .value (cnt_value),
    .dec   (cnt_dec),
    .zero  (cnt_zero)
  );

  // command crc x^7 + x^3 + 1
  sd_crc #(.WIDTH(7), .POLY(7'h09)) u_crc7 (
    .clock    (clock),
    .arst_n   (arst_n),
    .clear    (crc7_clear),
    .strobe   (crc7_strobe),
    .data_byte(crc7_byte),
    .crc      (crc7_value)
  );

  // ccitt data crc
  sd_crc #(.WIDTH(16), .POLY(16'h1021)) u_crc16 (
    .clock    (clock),
    .arst_n   (arst_n),
    .clear    (crc16_clear),
    .strobe   (crc16_strobe),
    .data_byte(crc16_byte),
    .crc      (crc16_value)
  );

endmodule

// File: tb/sd_card_model.sv
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_card_model (
  input  logic                            sck,
  input  logic                            cs_n,
  input  logic                            mosi,
  output logic                            miso,
  output logic [15:0][`SD_BLOCK_BITS-1:0] mem
);

  localparam int BITS  = `SD_BLOCK_BITS;
  localparam int BYTES = `SD_BLOCK_BYTES;

  typedef enum {HUNT, FRAME, TOKEN, DATA} mode_e;

  mode_e           mode;
  logic [7:0]      in_sh;
  logic [7:0]      out_sh;
  int              bit_cnt;
  logic            byte_end;
  logic [47:0]     frame;
  int              nbytes;
  logic            app_cmd;
  logic            powered_up;
  int              acmd41_seen;
  logic [3:0]      wr_blk;
  logic [BITS-1:0] wr_data;
  logic [15:0]     wr_crc;
  logic [7:0]      resp_q [$];

  initial begin
    mem         = '0;
    mode        = HUNT;
    in_sh       = 8'hff;
    out_sh      = 8'hff;
    bit_cnt     = 0;
    byte_end    = 1'b0;
    nbytes      = 0;
    app_cmd     = 1'b0;
    powered_up  = 1'b0;
    acmd41_seen = 0;
    miso        = 1'b1;
  end

  // x^7 + x^3 + 1 over the first five frame bytes
  function automatic logic [6:0] crc7_of(input logic [39:0] bits);
    logic [6:0] c;
    c = '0;
    for (int i = 39; i >= 0; i--) begin
      c = (c[6] ^ bits[i]) ? ({c[5:0], 1'b0} ^ 7'h09) : {c[5:0], 1'b0};
    end
    return c;
  endfunction

  // x^16 + x^12 + x^5 + 1 from a zero start
  function automatic logic [15:0] crc16_of(input logic [BITS-1:0] bits);
    logic [15:0] c;
    c = '0;
    for (int i = BITS - 1; i >= 0; i--) begin
      c = (c[15] ^ bits[i]) ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
    end
    return c;
  endfunction

  // r1 follows one filler byte
  task automatic reply_r1(input logic [7:0] r1);
    resp_q.push_back(8'hff);
    resp_q.push_back(r1);
  endtask

  task automatic run_command();
    logic [5:0]  idx;
    logic [31:0] arg;
    logic [15:0] crc;
    idx = frame[45:40];
    arg = frame[39:8];
    if (frame[7:1] != crc7_of(frame[47:8]) || !frame[0]) begin
      $display("card model: CMD%0d arrived with a bad CRC7 or end bit", idx);
      reply_r1(8'h08);
    end else if (!arg[6]) begin
      case (idx)
        sd_pkg::CMD_GO_IDLE: begin
          powered_up  = 1'b0;
          acmd41_seen = 0;
          reply_r1(sd_pkg::R1_IDLE);
        end
        sd_pkg::CMD_APP: begin
          reply_r1({7'd0, !powered_up});
        end
        sd_pkg::ACMD_OP: begin
          if (app_cmd) begin
            acmd41_seen++;
            powered_up = (acmd41_seen > 2);
            reply_r1(powered_up ? 8'h00 : sd_pkg::R1_IDLE);
          end else begin
            reply_r1(8'h04);
          end
        end
        sd_pkg::CMD_READ: begin
          reply_r1(8'h00);
          resp_q.push_back(8'hff);
          resp_q.push_back(sd_pkg::DATA_TOKEN);
          for (int i = BYTES - 1; i >= 0; i--) begin
            resp_q.push_back(mem[arg[3:0]][i*8 +: 8]);
          end
          crc = crc16_of(mem[arg[3:0]]);
          // corrupt crc16 on request
          if (arg[7]) begin
            crc = ~crc;
          end
          resp_q.push_back(crc[15:8]);
          resp_q.push_back(crc[7:0]);
        end
        sd_pkg::CMD_WRITE: begin
          reply_r1(8'h00);
          wr_blk = arg[3:0];
          mode   = TOKEN;
        end
        default: begin
          reply_r1(8'h04);
        end
      endcase
    end
    app_cmd = (idx == sd_pkg::CMD_APP);
  endtask

  task automatic store_block();
    if (crc16_of(wr_data) == wr_crc) begin
      mem[wr_blk] = wr_data;
      resp_q.push_back(sd_pkg::DRESP_OK);
      // busy while programming
      resp_q.push_back(8'h00);
      resp_q.push_back(8'h00);
    end else begin
      $display("card model: CRC16 mismatch on write to block %0d", wr_blk);
      resp_q.push_back(8'h0b);
    end
  endtask

  task automatic take_byte(input logic [7:0] b);
    case (mode)
      HUNT: begin
        if (b[7:6] == 2'b01) begin
          frame  = {40'd0, b};
          nbytes = 1;
          mode   = FRAME;
        end
      end
      FRAME: begin
        frame = {frame[39:0], b};
        nbytes++;
        if (nbytes == 6) begin
          mode = HUNT;
          run_command();
        end
      end
      TOKEN: begin
        if (b == sd_pkg::DATA_TOKEN) begin
          nbytes = 0;
          mode   = DATA;
        end
      end
      default: begin
        if (nbytes < BYTES) begin
          wr_data = {wr_data[BITS-9:0], b};
        end else begin
          wr_crc = {wr_crc[7:0], b};
        end
        nbytes++;
        if (nbytes == BYTES + 2) begin
          mode = HUNT;
          store_block();
        end
      end
    endcase
  endtask

  // mode 0 samples mosi on the rising edge and shifts miso on the falling edge
  always @(posedge sck or negedge sck or posedge cs_n) begin
    if (cs_n) begin
      bit_cnt  = 0;
      byte_end = 1'b0;
      mode     = HUNT;
      resp_q.delete();
      out_sh   = 8'hff;
      miso     = 1'b1;
    end else if (sck) begin
      in_sh = {in_sh[6:0], mosi};
      bit_cnt++;
      if (bit_cnt == 8) begin
        bit_cnt  = 0;
        byte_end = 1'b1;
        take_byte(in_sh);
      end
    end else begin
      if (byte_end) begin
        byte_end = 1'b0;
        out_sh   = (resp_q.size() > 0) ? resp_q.pop_front() : 8'hff;
      end else begin
        out_sh = {out_sh[6:0], 1'b1};
      end
      miso = out_sh[7];
    end
  end

endmodule

// File: tb/sd_checker.sv
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_checker (
  input  logic                            clock,
  input  logic                            arst_n,
  input  logic                            cyc,
  input  logic                            stb,
  input  logic                            wr,
  input  logic [31:0]                     addr,
  input  logic [`SD_BLOCK_BITS-1:0]       wdata,
  input  logic [`SD_BLOCK_BITS-1:0]       rdata,
  input  logic                            ack,
  input  logic                            err,
  input  logic                            ready,
  input  logic [15:0][`SD_BLOCK_BITS-1:0] card_mem,
  output int                              error_count,
  output int                              ack_count
);

  logic [`SD_BLOCK_BITS-1:0] shadow [16];
  logic                      ready_seen;

  initial begin
    error_count = 0;
    ack_count   = 0;
    ready_seen  = 1'b0;
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
  end

  task automatic report(input string msg);
    $display("protocol error at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic check_response();
    logic [3:0] blk;
    logic       exp_err;
    blk = addr[3:0];
    // a silent card times out and a read with a bad crc16 is rejected
    exp_err = addr[6] || (!wr && addr[7]);
    if (err !== exp_err) begin
      $display("FAILED %0t: %s of block %0d at addr %h ended with err %b, expected %b",
               $time, wr ? "write" : "read", blk, addr, err, exp_err);
      error_count++;
    end else if (!err && wr) begin
      shadow[blk] = wdata;
      if (card_mem[blk] !== wdata) begin
        $display("FAILED %0t: card block %0d holds %h after a write of %h",
                 $time, blk, card_mem[blk], wdata);
        error_count++;
      end
    end else if (!err && rdata !== shadow[blk]) begin
      $display("FAILED %0t: read of block %0d returned %h, expected %h",
               $time, blk, rdata, shadow[blk]);
      error_count++;
    end
  endtask

  always @(posedge clock) begin
    if (arst_n) begin
      if (ready) begin
        ready_seen = 1'b1;
      end else if (ready_seen) begin
        report("ready fell after initialization had finished");
      end
      if (ack) begin
        ack_count++;
        if (!ready_seen) begin
          report("ack arrived before ready");
        end
        if (!(cyc && stb)) begin
          report("ack arrived without an active request");
        end else begin
          check_response();
        end
      end
    end
  end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/1ps
`include "sd_macros.svh"

module tb_top;

  localparam int BITS           = `SD_BLOCK_BITS;
  localparam int NUM_TXN        = 60;
  localparam int TXN_MAX_CYCLES = 1200;
  localparam int INIT_CYCLES    = 4000;
  localparam int CYCLE_LIMIT    = 5 + INIT_CYCLES + NUM_TXN * (TXN_MAX_CYCLES + 4);

  logic                       clock;
  logic                       arst_n;
  logic                       cyc;
  logic                       stb;
  logic                       wr;
  logic [31:0]                addr;
  logic [BITS-1:0]            wdata;
  logic [BITS-1:0]            rdata;
  logic                       ack;
  logic                       err;
  logic                       ready;
  logic                       miso;
  logic                       cs_n;
  logic                       sck;
  logic                       mosi;
  logic [15:0][BITS-1:0]      card_mem;
  int                         error_count;
  int                         ack_count;
  int                         issued;
  int                         seed;
  int                         cycles = 0;

  sd_controller_top UUT (
    .clock (clock),
    .arst_n(arst_n),
    .cyc   (cyc),
    .stb   (stb),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .ack   (ack),
    .err   (err),
    .ready (ready),
    .miso  (miso),
    .cs_n  (cs_n),
    .sck   (sck),
    .mosi  (mosi)
  );

  sd_card_model u_card (
    .sck (sck),
    .cs_n(cs_n),
    .mosi(mosi),
    .miso(miso),
    .mem (card_mem)
  );

  sd_checker u_check (
    .clock      (clock),
    .arst_n     (arst_n),
    .cyc        (cyc),
    .stb        (stb),
    .wr         (wr),
    .addr       (addr),
    .wdata      (wdata),
    .rdata      (rdata),
    .ack        (ack),
    .err        (err),
    .ready      (ready),
    .card_mem   (card_mem),
    .error_count(error_count),
    .ack_count  (ack_count)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, errors: %0d, acked: %0d of %0d issued",
               CYCLE_LIMIT, error_count, ack_count, issued);
      $display("tests failed");
      $finish;
    end
  end

  // one random block access held until ack
  task automatic do_transfer();
    logic [31:0]     r;
    logic [BITS-1:0] data;
    r = $random(seed);
    for (int i = 0; i < BITS / 32; i++) begin
      data[i*32 +: 32] = $random(seed);
    end
    @(posedge clock);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    wr    <= r[0];
    // bit 7 corrupts a read crc and bit 6 silences the card
    addr  <= {24'h0, (r[3:1] == 3'd0), (r[6:4] == 3'd0), 2'b00, r[11:8]};
    wdata <= data;
    do begin
      @(posedge clock);
    end while (!ack);
    cyc <= 1'b0;
    stb <= 1'b0;
    repeat (r[13:12]) @(posedge clock);
  endtask

  initial begin
    seed   = 32'h3ff3abd3;
    issued = 0;
    arst_n = 1'b0;
    cyc    = 1'b0;
    stb    = 1'b0;
    wr     = 1'b0;
    addr   = '0;
    wdata  = '0;
    repeat (5) @(posedge clock);
    arst_n <= 1'b1;
    while (!ready) @(posedge clock);
    repeat (NUM_TXN) begin
      do_transfer();
      issued++;
    end
    @(posedge clock);
    $display("errors: %0d, transactions issued: %0d, acked: %0d",
             error_count, issued, ack_count);
    if (error_count == 0 && ack_count == issued) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+design
design/sd_pkg.sv
design/sd_spi_if.sv
design/sd_spi_shifter.sv
design/sd_byte_counter.sv
design/sd_crc.sv
design/sd_controller.sv
design/sd_controller_top.sv
tb/sd_card_model.sv
tb/sd_checker.sv
tb/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_top -f tb.f -o tb_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/tb_sim); then
  echo "$sim_out"
  echo "simulation exited with an error status"
  exit 1
fi

echo "$sim_out"

if grep -qx "all tests passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
